//--- hdl/systolic_pkg.sv
`default_nettype none

package systolic_pkg;

    // operand and product widths
    parameter int DATA_WIDTH = 8;
    parameter int NUM_DIGITS = (DATA_WIDTH + 2) / 3;
    parameter int PROD_WIDTH = 2 * DATA_WIDTH;

    // operand/digit register, compressor input, compressor stage, sum
    parameter int MULT_LATENCY = 4;

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic signed [PROD_WIDTH-1:0] prod_t;
    typedef logic signed [DATA_WIDTH+1:0] triple_t;
    typedef logic [NUM_DIGITS-1:0] digit_bits_t;

    // multiple of the operand picked for one partial product
    typedef enum logic [3:0] {
        ZERO,
        PLUS_ONE,
        PLUS_TWO,
        PLUS_THREE,
        PLUS_FOUR,
        MINUS_ONE,
        MINUS_TWO,
        MINUS_THREE,
        MINUS_FOUR
    } pp_sel_e;

endpackage

`default_nettype wire

//--- hdl/booth_digit_if.sv
`timescale 1ns/10ps
`default_nettype none

// one radix-8 digit set, one bit per digit position in each field
interface booth_digit_if;
    systolic_pkg::digit_bits_t s;
    systolic_pkg::digit_bits_t t;
    systolic_pkg::digit_bits_t d;
    systolic_pkg::digit_bits_t q;
    systolic_pkg::digit_bits_t n;

    // driven by a recoder or by the element on the left
    modport src (output s, t, d, q, n);

    // read by the element on the right
    modport dst (input s, t, d, q, n);
endinterface

`default_nettype wire

//--- hdl/booth_recoder.sv
`timescale 1ns/10ps
`default_nettype none

module booth_recoder (
    input  logic                clk,
    input  logic                rst,
    input  systolic_pkg::data_t operand,
    booth_digit_if.src          digits
);

    logic [3*systolic_pkg::NUM_DIGITS:0] ext;
    systolic_pkg::digit_bits_t hi_x;
    systolic_pkg::digit_bits_t mid_x;
    systolic_pkg::digit_bits_t lo_x;
    systolic_pkg::digit_bits_t sign;

    // sign bit repeated on top, implicit zero below the lsb
    assign ext = {operand[systolic_pkg::DATA_WIDTH-1], operand, 1'b0};

    // neighbour xors of each overlapping four-bit window
    always_comb begin
        for (int i = 0; i < systolic_pkg::NUM_DIGITS; i++) begin
            hi_x[i]  = ext[3*i+3] ^ ext[3*i+2];
            mid_x[i] = ext[3*i+2] ^ ext[3*i+1];
            lo_x[i]  = ext[3*i+1] ^ ext[3*i];
            sign[i]  = ext[3*i+3];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            // code of a zero digit
            digits.s <= '1;
            digits.d <= '1;
            digits.t <= '0;
            digits.q <= '0;
            digits.n <= '0;
        end else begin
            digits.s <= ~(hi_x ^ lo_x);
            digits.d <= ~(mid_x ^ lo_x);
            digits.t <= hi_x ^ lo_x;
            digits.q <= hi_x ^ mid_x ^ lo_x;
            digits.n <= sign;
        end
    end

endmodule

`default_nettype wire

//--- hdl/wallace_adder.sv
`timescale 1ns/10ps
`default_nettype none

module wallace_adder (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [systolic_pkg::PROD_WIDTH-1:0] pp0,
    input  logic [systolic_pkg::PROD_WIDTH-4:0] pp1,
    input  logic [systolic_pkg::PROD_WIDTH-7:0] pp2,
    output systolic_pkg::prod_t                 sum
);

    // partials at weights 0, 3 and 6
    logic [15:0] r0;
    logic [12:0] r1;
    logic [9:0]  r2;

    logic        ha_sum;
    logic        ha_carry;
    logic [15:7] fa_sum;
    logic [14:7] fa_carry;

    logic        ha_sum_q;
    logic        ha_carry_q;
    logic [15:7] fa_sum_q;
    logic [14:7] fa_carry_q;
    logic [5:0]  low_a_q;
    logic [3:0]  low_b_q;

    logic [15:0] row_a;
    logic [15:0] row_b;

    // column 6 holds three bits, the third one passes down as a carry-row bit
    always_comb begin
        ha_sum   = r0[6] ^ r1[3];
        ha_carry = r0[6] & r1[3];
        for (int c = 7; c < 16; c++) begin
            fa_sum[c] = r0[c] ^ r1[c-3] ^ r2[c-6];
        end
        // carry out of column 15 falls off the 16-bit result
        for (int c = 7; c < 15; c++) begin
            fa_carry[c] = (r0[c] & r1[c-3]) | (r0[c] & r2[c-6]) | (r1[c-3] & r2[c-6]);
        end
    end

    assign row_a = {fa_sum_q, ha_sum_q, low_a_q};
    assign row_b = {fa_carry_q, ha_carry_q, low_b_q, 3'b000};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            r0         <= '0;
            r1         <= '0;
            r2         <= '0;
            ha_sum_q   <= 1'b0;
            ha_carry_q <= 1'b0;
            fa_sum_q   <= '0;
            fa_carry_q <= '0;
            low_a_q    <= '0;
            low_b_q    <= '0;
            sum        <= '0;
        end else begin
            r0         <= pp0;
            r1         <= pp1;
            r2         <= pp2;
            ha_sum_q   <= ha_sum;
            ha_carry_q <= ha_carry;
            fa_sum_q   <= fa_sum;
            fa_carry_q <= fa_carry;
            // columns 0..6 skip the compressor
            low_a_q    <= r0[5:0];
            low_b_q    <= {r2[0], r1[2:0]};
            sum        <= row_a + row_b;
        end
    end

    a_sum_known: assert property (@(posedge clk) disable iff (!rst) !$isunknown(sum))
        else $error("compressor sum is unknown");

endmodule

`default_nettype wire

//--- hdl/booth_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

module booth_multiplier (
    input  logic                clk,
    input  logic                rst,
    input  systolic_pkg::data_t operand,
    booth_digit_if.dst          digits,
    output systolic_pkg::prod_t product
);

    systolic_pkg::data_t     op_q;
    systolic_pkg::triple_t   triple;
    systolic_pkg::prod_t     one_m;
    systolic_pkg::prod_t     two_m;
    systolic_pkg::prod_t     three_m;
    systolic_pkg::prod_t     four_m;
    systolic_pkg::pp_sel_e   sel [systolic_pkg::NUM_DIGITS];
    systolic_pkg::prod_t     pp [systolic_pkg::NUM_DIGITS];
    systolic_pkg::digit_bits_t code_ok;

    // lines up with the digit register of the recoder or left element
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            op_q <= '0;
        end else begin
            op_q <= operand;
        end
    end

    // 3y needs a real adder, the rest are shifts
    assign triple  = systolic_pkg::triple_t'(op_q) + (systolic_pkg::triple_t'(op_q) <<< 1);
    assign one_m   = systolic_pkg::prod_t'(op_q);
    assign two_m   = one_m <<< 1;
    assign three_m = systolic_pkg::prod_t'(triple);
    assign four_m  = one_m <<< 2;

    // digit code is {s, d, t, q, n}
    always_comb begin
        for (int i = 0; i < systolic_pkg::NUM_DIGITS; i++) begin
            code_ok[i] = 1'b1;
            case ({digits.s[i], digits.d[i], digits.t[i], digits.q[i], digits.n[i]})
                5'b11000, 5'b11001: sel[i] = systolic_pkg::ZERO;
                5'b00110, 5'b01100: sel[i] = systolic_pkg::PLUS_ONE;
                5'b10010, 5'b00100: sel[i] = systolic_pkg::PLUS_TWO;
                5'b11010, 5'b10000: sel[i] = systolic_pkg::PLUS_THREE;
                5'b01110:           sel[i] = systolic_pkg::PLUS_FOUR;
                5'b00111, 5'b01101: sel[i] = systolic_pkg::MINUS_ONE;
                5'b00101, 5'b10011: sel[i] = systolic_pkg::MINUS_TWO;
                5'b10001, 5'b11011: sel[i] = systolic_pkg::MINUS_THREE;
                5'b01111:           sel[i] = systolic_pkg::MINUS_FOUR;
                default: begin
                    sel[i]     = systolic_pkg::ZERO;
                    code_ok[i] = 1'b0;
                end
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < systolic_pkg::NUM_DIGITS; i++) begin
            case (sel[i])
                systolic_pkg::PLUS_ONE:    pp[i] = one_m;
                systolic_pkg::PLUS_TWO:    pp[i] = two_m;
                systolic_pkg::PLUS_THREE:  pp[i] = three_m;
                systolic_pkg::PLUS_FOUR:   pp[i] = four_m;
                systolic_pkg::MINUS_ONE:   pp[i] = -one_m;
                systolic_pkg::MINUS_TWO:   pp[i] = -two_m;
                systolic_pkg::MINUS_THREE: pp[i] = -three_m;
                systolic_pkg::MINUS_FOUR:  pp[i] = -four_m;
                default:                   pp[i] = '0;
            endcase
        end
    end

    // higher partials are trimmed to the columns they still reach
    wallace_adder u_wallace (
        .clk (clk),
        .rst (rst),
        .pp0 (pp[0]),
        .pp1 (pp[1][systolic_pkg::PROD_WIDTH-4:0]),
        .pp2 (pp[2][systolic_pkg::PROD_WIDTH-7:0]),
        .sum (product)
    );

    // recoder output must always be one of the sixteen window codes
    a_digit_code_valid: assert property (@(posedge clk) disable iff (!rst) &code_ok)
        else $error("Booth digit set holds an undefined code");

endmodule

`default_nettype wire

//--- hdl/mac_pe.sv
`timescale 1ns/10ps
`default_nettype none

module mac_pe (
    input  logic                clk,
    input  logic                rst,
    input  logic                clear,
    input  systolic_pkg::data_t operand_in,
    output systolic_pkg::data_t operand_out,
    booth_digit_if.dst          digits_in,
    booth_digit_if.src          digits_out,
    output systolic_pkg::prod_t acc
);

    systolic_pkg::prod_t product;

    // operand goes down, digit set goes right
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            operand_out  <= '0;
            digits_out.s <= '1;
            digits_out.d <= '1;
            digits_out.t <= '0;
            digits_out.q <= '0;
            digits_out.n <= '0;
        end else begin
            operand_out  <= operand_in;
            digits_out.s <= digits_in.s;
            digits_out.d <= digits_in.d;
            digits_out.t <= digits_in.t;
            digits_out.q <= digits_in.q;
            digits_out.n <= digits_in.n;
        end
    end

    booth_multiplier u_mult (
        .clk     (clk),
        .rst     (rst),
        .operand (operand_in),
        .digits  (digits_in),
        .product (product)
    );

    // wraps modulo 2^16
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else begin
            acc <= acc + product;
        end
    end

endmodule

`default_nettype wire

//--- hdl/systolic_array.sv
`timescale 1ns/10ps
`default_nettype none

module systolic_array #(
    parameter int SIZE = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  systolic_pkg::data_t a_in [SIZE],
    input  systolic_pkg::data_t b_in [SIZE],
    output systolic_pkg::prod_t c_out [SIZE][SIZE],
    output logic                done
);

    // stream steps and multiplier, then input, accumulator and output
    // registers plus one spare edge
    localparam int DONE_COUNT = (3 * SIZE - 2) + systolic_pkg::MULT_LATENCY + 4;
    localparam int CNT_W = $clog2(DONE_COUNT + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } state_e;

    state_e              state;
    logic [CNT_W-1:0]    count;
    systolic_pkg::data_t a_q [SIZE];
    systolic_pkg::data_t b_q [SIZE];
    systolic_pkg::data_t col_link [SIZE+1][SIZE];
    systolic_pkg::prod_t acc [SIZE][SIZE];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int k = 0; k < SIZE; k++) begin
                a_q[k] <= '0;
                b_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < SIZE; k++) begin
                a_q[k] <= a_in[k];
                b_q[k] <= b_in[k];
            end
        end
    end

    // top of each column
    for (genvar j = 0; j < SIZE; j++) begin : g_col_in
        assign col_link[0][j] = b_q[j];
    end

    for (genvar i = 0; i < SIZE; i++) begin : g_row
        // link[0] comes from the recoder and link[j+1] out of element j
        booth_digit_if link [SIZE+1] ();

        booth_recoder u_rec (
            .clk     (clk),
            .rst     (rst),
            .operand (a_q[i]),
            .digits  (link[0])
        );

        for (genvar j = 0; j < SIZE; j++) begin : g_col
            mac_pe u_pe (
                .clk         (clk),
                .rst         (rst),
                .clear       (start),
                .operand_in  (col_link[i][j]),
                .operand_out (col_link[i+1][j]),
                .digits_in   (link[j]),
                .digits_out  (link[j+1]),
                .acc         (acc[i][j])
            );
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int r = 0; r < SIZE; r++) begin
                for (int c = 0; c < SIZE; c++) begin
                    c_out[r][c] <= '0;
                end
            end
        end else begin
            c_out <= acc;
        end
    end

    // completion counter restarted by every start
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
            count <= '0;
        end else if (start) begin
            state <= ST_RUN;
            count <= '0;
        end else if (state == ST_RUN) begin
            count <= count + 1'b1;
            if (count == CNT_W'(DONE_COUNT - 1)) begin
                state <= ST_DONE;
            end
        end
    end

    assign done = (state == ST_DONE);

    // done rises only a fixed count of edges after the latest start
    a_done_after_start: assert property (@(posedge clk) disable iff (!rst)
        $rose(done) |-> $past(start, DONE_COUNT + 1))
        else $error("done rose at the wrong distance from start");

endmodule

`default_nettype wire

//--- sim/tb_systolic_array.sv
`timescale 1ns/10ps
`default_nettype none

module tb_systolic_array;

    localparam int N = 3;
    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int DONE_EDGES = 3 * N + 6;
    // identity, two extreme, five random and two back-to-back products
    localparam int NUM_RUNS = 10;
    localparam int WATCHDOG_CYCLES = 2 * (10 + NUM_RUNS * (DONE_EDGES + 4));

    logic                clk;
    logic                rst;
    logic                start;
    systolic_pkg::data_t a_in [N];
    systolic_pkg::data_t b_in [N];
    systolic_pkg::prod_t c_out [N][N];
    logic                done;

    systolic_pkg::data_t a_mat [N][N];
    systolic_pkg::data_t b_mat [N][N];
    logic signed [15:0]  exp_mat [N][N];
    logic [15:0]         lfsr_state;
    int                  error_count;

    systolic_array #(.SIZE(N)) u_dut (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .a_in  (a_in),
        .b_in  (b_in),
        .c_out (c_out),
        .done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests ran longer than the expected run time");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] shifted;
        shifted = state >> 1;
        // taps 16, 14, 13, 11
        if (state[0]) begin
            shifted = shifted ^ 16'hB400;
        end
        return shifted;
    endfunction

    // one lfsr step per bit
    task automatic random_byte(output systolic_pkg::data_t value);
        for (int b = 0; b < 8; b++) begin
            value[b] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_equal(input logic signed [31:0] actual,
                               input logic signed [31:0] expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // wrapped matrix product
    task automatic compute_expected();
        int sum;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                sum = 0;
                for (int k = 0; k < N; k++) begin
                    sum += int'(a_mat[i][k]) * int'(b_mat[k][j]);
                end
                exp_mat[i][j] = sum[15:0];
            end
        end
    endtask

    // diagonal skew with all zeros for a negative step
    task automatic drive_step(input int k);
        int idx;
        for (int i = 0; i < N; i++) begin
            idx = k - i;
            if (k >= 0 && idx >= 0 && idx < N) begin
                a_in[i] = a_mat[i][idx];
                b_in[i] = b_mat[idx][i];
            end else begin
                a_in[i] = '0;
                b_in[i] = '0;
            end
        end
    endtask

    task automatic check_all_zero(input string name);
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                check_equal(c_out[i][j], 0, $sformatf("%s: c_out[%0d][%0d] zero", name, i, j));
            end
        end
    endtask

    task automatic run_product(input string name);
        int edges;
        // start cycle carries no data
        start = 1'b1;
        drive_step(-1);
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        check_equal(done, 0, {name, ": done dropped by start"});
        drive_step(0);
        edges = 0;
        while (!done) begin
            @(posedge clk);
            #DRIVE_DELAY;
            edges++;
            if (edges == 1) begin
                check_all_zero({name, " after clear"});
            end
            drive_step(edges);
            if (edges > 4 * DONE_EDGES) begin
                $display("%s: done did not rise within %0d clock edges", name, edges);
                $display("tests failed");
                $fatal(1, "done never rose");
            end
        end
        check_equal(edges, DONE_EDGES, {name, ": edges from start to done"});
        compute_expected();
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                check_equal(c_out[i][j], exp_mat[i][j],
                            $sformatf("%s: c_out[%0d][%0d]", name, i, j));
            end
        end
    endtask

    task automatic load_random();
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                random_byte(a_mat[i][j]);
                random_byte(b_mat[i][j]);
            end
        end
    endtask

    task automatic test_reset_state();
        check_equal(done, 0, "done after reset");
        check_all_zero("reset");
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        check_equal(done, 0, "done idle before start");
        check_all_zero("idle");
    endtask

    task automatic test_identity();
        int fixed_b [N][N];
        fixed_b = '{'{5, -7, 12}, '{-3, 0, 100}, '{127, -128, 9}};
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                a_mat[i][j] = systolic_pkg::data_t'((i == j) ? 1 : 0);
                b_mat[i][j] = systolic_pkg::data_t'(fixed_b[i][j]);
            end
        end
        run_product("identity");
        // I * B returns B
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                check_equal(c_out[i][j], b_mat[i][j], $sformatf("identity: B[%0d][%0d]", i, j));
            end
        end
    endtask

    task automatic test_signed_extremes();
        int ext_a [N][N];
        int ext_b [N][N];
        // three times 16384 wraps to -16384
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                a_mat[i][j] = systolic_pkg::data_t'(-128);
                b_mat[i][j] = systolic_pkg::data_t'(-128);
            end
        end
        run_product("all -128");
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                check_equal(c_out[i][j], -16384, $sformatf("wrapped sum [%0d][%0d]", i, j));
            end
        end
        ext_a = '{'{127, -128, -1}, '{-1, -1, -1}, '{-128, 127, 127}};
        ext_b = '{'{-128, 127, -1}, '{127, -1, -128}, '{-1, -128, 127}};
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                a_mat[i][j] = systolic_pkg::data_t'(ext_a[i][j]);
                b_mat[i][j] = systolic_pkg::data_t'(ext_b[i][j]);
            end
        end
        run_product("mixed extremes");
    endtask

    task automatic test_random_products();
        for (int r = 0; r < 5; r++) begin
            load_random();
            run_product($sformatf("random %0d", r));
        end
    endtask

    task automatic test_back_to_back();
        load_random();
        run_product("first of pair");
        // done and the result hold while zeros stream in
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        check_equal(done, 1, "done held before second start");
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                check_equal(c_out[i][j], exp_mat[i][j],
                            $sformatf("first of pair held: c_out[%0d][%0d]", i, j));
            end
        end
        // second start while done is still high
        load_random();
        run_product("second of pair");
    endtask

    initial begin
        error_count = 0;
        lfsr_state = 16'd15;
        rst = 1'b0;
        start = 1'b0;
        for (int i = 0; i < N; i++) begin
            a_in[i] = '0;
            b_in[i] = '0;
        end
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;

        test_reset_state();
        test_identity();
        test_signed_extremes();
        test_random_products();
        test_back_to_back();

        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hdl/systolic_pkg.sv
hdl/booth_digit_if.sv
hdl/booth_recoder.sv
hdl/wallace_adder.sv
hdl/booth_multiplier.sv
hdl/mac_pe.sv
hdl/systolic_array.sv
sim/tb_systolic_array.sv

//--- run_sim.sh
#!/bin/bash
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_systolic_array -f project.f \
    -o tb_systolic_array > build.log 2>&1 \
    && ./obj_dir/tb_systolic_array > sim.log 2>&1 \
    || { echo "build or run did not complete, see build.log and sim.log"; exit 1; }
grep -q "all tests passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
